/* include/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// address and register width
`define DC_XLEN 32

// one cache line holds 8 bytes
`define DC_BLOCK_BITS 64
`define DC_OFFSET_BITS 3

// direct-mapped main cache
`define DC_INDEX_BITS 4
`define DC_N_LINES 16
`define DC_TAG_BITS (`DC_XLEN - `DC_INDEX_BITS - `DC_OFFSET_BITS)

// victim cache tag is the whole line address
`define DC_VC_LINES 4
`define DC_VC_TAG_BITS (`DC_XLEN - `DC_OFFSET_BITS)

// tag returned by memory with load data
`define DC_MEM_TAG_BITS 4

`endif

/* hw/dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

    typedef enum logic [1:0] {
        cmd_none  = 2'd0,
        cmd_load  = 2'd1,
        cmd_store = 2'd2
    } mem_cmd_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        logic [`DC_TAG_BITS-1:0]     tag;
        logic [`DC_BLOCK_BITS-1:0]   block;
    } main_line_t;

    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        logic [1:0]                  lru;   // higher means more recently used
        logic [`DC_VC_TAG_BITS-1:0]  tag;
        logic [`DC_BLOCK_BITS-1:0]   block;
    } victim_line_t;

    // replace the addressed byte, half or word of a line, little endian
    function automatic logic [`DC_BLOCK_BITS-1:0] merge_store(
        input logic [`DC_BLOCK_BITS-1:0] block,
        input logic [`DC_OFFSET_BITS-1:0] offset,
        input mem_size_t size,
        input logic [`DC_XLEN-1:0] wdata
    );
        logic [`DC_BLOCK_BITS-1:0] result;
        result = block;
        case (size)
            size_byte: result[{offset, 3'b000} +: 8] = wdata[7:0];
            size_half: result[{offset[2:1], 4'b0000} +: 16] = wdata[15:0];
            size_word: result[{offset[2], 5'b00000} +: 32] = wdata;
            default: result = block;
        endcase
        return result;
    endfunction

    // pick the addressed bytes out of a line, zero extended
    function automatic logic [`DC_XLEN-1:0] extract_load(
        input logic [`DC_BLOCK_BITS-1:0] block,
        input logic [`DC_OFFSET_BITS-1:0] offset,
        input mem_size_t size
    );
        logic [`DC_XLEN-1:0] result;
        result = '0;
        case (size)
            size_byte: result[7:0] = block[{offset, 3'b000} +: 8];
            size_half: result[15:0] = block[{offset[2:1], 4'b0000} +: 16];
            size_word: result = block[{offset[2], 5'b00000} +: 32];
            default: result = '0;
        endcase
        return result;
    endfunction

endpackage

/* hw/dcache_ctrl.sv */
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          req_valid,
    input  logic                          req_write,
    input  dcache_pkg::mem_size_t         req_size,
    input  logic [`DC_XLEN-1:0]           req_addr,
    input  logic [`DC_XLEN-1:0]           req_wdata,
    input  logic                          main_hit,
    input  logic [`DC_BLOCK_BITS-1:0]     main_hit_block,
    input  logic                          vc_hit,
    input  logic [`DC_BLOCK_BITS-1:0]     vc_hit_block,
    input  logic                          fill_valid,
    input  logic [`DC_BLOCK_BITS-1:0]     fill_block,
    output logic                          stall,
    output logic                          resp_valid,
    output logic [`DC_XLEN-1:0]           resp_data,
    output logic                          miss_start,
    output logic [`DC_XLEN-1:0]           miss_addr,
    output logic                          hold_write,
    output dcache_pkg::mem_size_t         hold_size,
    output logic [`DC_XLEN-1:0]           hold_addr,
    output logic [`DC_XLEN-1:0]           hold_wdata
);

    typedef enum logic {st_ready, st_wait_fill} ctrl_state_t;

    ctrl_state_t state;
    logic accept;
    logic any_hit;
    logic [`DC_BLOCK_BITS-1:0] hit_block;

    assign stall = (state == st_wait_fill);
    assign accept = req_valid && (state == st_ready);
    assign any_hit = main_hit || vc_hit;
    assign hit_block = main_hit ? main_hit_block : vc_hit_block;
    assign miss_addr = hold_addr;   // miss unit aligns it to the line

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_ready;
            resp_valid <= 1'b0;
            miss_start <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            miss_start <= 1'b0;
            if (accept && any_hit) begin
                resp_valid <= 1'b1;
            end else if (accept) begin
                state      <= st_wait_fill;
                miss_start <= 1'b1;
            end else if (stall && fill_valid) begin
                state      <= st_ready;
                resp_valid <= 1'b1;
            end
        end
    end

    // response data and the held miss request
    always_ff @(posedge clock) begin
        if (accept && any_hit) begin
            resp_data <= dcache_pkg::extract_load(hit_block, req_addr[2:0], req_size);
        end else if (stall && fill_valid) begin
            resp_data <= dcache_pkg::extract_load(fill_block, hold_addr[2:0], hold_size);
        end
        if (accept && !any_hit) begin
            hold_write <= req_write;
            hold_size  <= req_size;
            hold_addr  <= req_addr;
            hold_wdata <= req_wdata;
        end
    end

endmodule

/* hw/main_cache_array.sv */
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module main_cache_array (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          req_valid,
    input  logic                          req_write,
    input  dcache_pkg::mem_size_t         req_size,
    input  logic [`DC_XLEN-1:0]           req_addr,
    input  logic [`DC_XLEN-1:0]           req_wdata,
    input  logic                          stall,
    input  logic                          hold_write,
    input  dcache_pkg::mem_size_t         hold_size,
    input  logic [`DC_XLEN-1:0]           hold_addr,
    input  logic [`DC_XLEN-1:0]           hold_wdata,
    input  logic                          fill_valid,
    input  logic [`DC_XLEN-1:0]           fill_addr,
    input  logic [`DC_BLOCK_BITS-1:0]     fill_block,
    output logic                          main_hit,
    output logic [`DC_BLOCK_BITS-1:0]     main_hit_block,
    output logic                          evict_valid,
    output dcache_pkg::main_line_t        evict_line,
    output logic [`DC_XLEN-1:0]           evict_addr
);

    dcache_pkg::main_line_t lines [`DC_N_LINES];

    logic [`DC_INDEX_BITS-1:0] req_idx;
    logic [`DC_TAG_BITS-1:0]   req_tag;
    logic [`DC_INDEX_BITS-1:0] fill_idx;
    logic [`DC_TAG_BITS-1:0]   fill_tag;
    logic                      store_hit;
    logic [`DC_BLOCK_BITS-1:0] fill_data;

    assign req_idx  = req_addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign req_tag  = req_addr[`DC_XLEN-1 -: `DC_TAG_BITS];
    assign fill_idx = fill_addr[`DC_OFFSET_BITS +: `DC_INDEX_BITS];
    assign fill_tag = fill_addr[`DC_XLEN-1 -: `DC_TAG_BITS];

    // hit check on the live request
    assign main_hit = req_valid && lines[req_idx].valid && (lines[req_idx].tag == req_tag);
    assign main_hit_block = lines[req_idx].block;
    assign store_hit = main_hit && req_write && !stall;

    // old line at the fill index moves to the victim cache
    assign evict_line  = lines[fill_idx];
    assign evict_valid = fill_valid && lines[fill_idx].valid;
    assign evict_addr  = {lines[fill_idx].tag, fill_idx, {`DC_OFFSET_BITS{1'b0}}};

    // a held store lands on top of the incoming line
    assign fill_data = hold_write ?
        dcache_pkg::merge_store(fill_block, hold_addr[2:0], hold_size, hold_wdata) :
        fill_block;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DC_N_LINES; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else if (fill_valid) begin
            lines[fill_idx].valid <= 1'b1;
            lines[fill_idx].dirty <= hold_write;   // clean for a load
            lines[fill_idx].tag   <= fill_tag;
            lines[fill_idx].block <= fill_data;
        end else if (store_hit) begin
            lines[req_idx].dirty <= 1'b1;
            lines[req_idx].block <= dcache_pkg::merge_store(lines[req_idx].block,
                                                            req_addr[2:0], req_size, req_wdata);
        end
    end

endmodule

/* hw/victim_cache.sv */
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module victim_cache (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          req_valid,
    input  logic                          req_write,
    input  dcache_pkg::mem_size_t         req_size,
    input  logic [`DC_XLEN-1:0]           req_addr,
    input  logic [`DC_XLEN-1:0]           req_wdata,
    input  logic                          stall,
    input  logic                          evict_valid,
    input  dcache_pkg::main_line_t        evict_line,
    input  logic [`DC_XLEN-1:0]           evict_addr,
    output logic                          vc_hit,
    output logic [`DC_BLOCK_BITS-1:0]     vc_hit_block,
    output logic                          vc_wb_valid,
    output logic [`DC_XLEN-1:0]           vc_wb_addr,
    output logic [`DC_BLOCK_BITS-1:0]     vc_wb_block
);

    localparam int VC_IDX_BITS = $clog2(`DC_VC_LINES);

    dcache_pkg::victim_line_t lines [`DC_VC_LINES];

    logic [`DC_VC_TAG_BITS-1:0] req_tag;
    logic [VC_IDX_BITS-1:0]     hit_idx;
    logic [VC_IDX_BITS-1:0]     ins_idx;
    logic                       free_found;
    logic [1:0]                 min_lru;
    logic                       hit_update;

    assign req_tag = req_addr[`DC_XLEN-1 -: `DC_VC_TAG_BITS];

    // associative lookup
    always_comb begin
        vc_hit  = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < `DC_VC_LINES; i++) begin
            if (!vc_hit && req_valid && lines[i].valid && (lines[i].tag == req_tag)) begin
                vc_hit  = 1'b1;
                hit_idx = VC_IDX_BITS'(i);
            end
        end
    end

    assign vc_hit_block = lines[hit_idx].block;
    assign hit_update = vc_hit && !stall;

    // free line first, otherwise lowest lru, first index wins ties
    always_comb begin
        free_found = 1'b0;
        ins_idx    = '0;
        min_lru    = '1;
        for (int i = 0; i < `DC_VC_LINES; i++) begin
            if (!free_found && !lines[i].valid) begin
                free_found = 1'b1;
                ins_idx    = VC_IDX_BITS'(i);
            end
        end
        if (!free_found) begin
            ins_idx = '0;
            min_lru = lines[0].lru;
            for (int i = 1; i < `DC_VC_LINES; i++) begin
                if (lines[i].lru < min_lru) begin
                    min_lru = lines[i].lru;
                    ins_idx = VC_IDX_BITS'(i);
                end
            end
        end
    end

    // displaced dirty line goes back to memory, clean one is dropped
    assign vc_wb_valid = evict_valid && !free_found && lines[ins_idx].dirty;
    assign vc_wb_addr  = {lines[ins_idx].tag, {`DC_OFFSET_BITS{1'b0}}};
    assign vc_wb_block = lines[ins_idx].block;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `DC_VC_LINES; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
                lines[i].lru   <= '0;
            end
        end else begin
            if (hit_update) begin
                for (int i = 0; i < `DC_VC_LINES; i++) begin
                    if (i == int'(hit_idx)) begin
                        lines[i].lru <= '1;
                    end else if (lines[i].lru != 2'd0) begin
                        lines[i].lru <= lines[i].lru - 2'd1;   // saturates at zero
                    end
                end
                if (req_write) begin
                    lines[hit_idx].dirty <= 1'b1;
                    lines[hit_idx].block <= dcache_pkg::merge_store(lines[hit_idx].block,
                                                                    req_addr[2:0], req_size,
                                                                    req_wdata);
                end
            end
            if (evict_valid) begin
                lines[ins_idx].valid <= 1'b1;
                lines[ins_idx].dirty <= evict_line.dirty;
                lines[ins_idx].lru   <= 2'd0;
                lines[ins_idx].tag   <= evict_addr[`DC_XLEN-1 -: `DC_VC_TAG_BITS];
                lines[ins_idx].block <= evict_line.block;
            end
        end
    end

endmodule

/* hw/miss_unit.sv */
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module miss_unit (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          miss_start,
    input  logic [`DC_XLEN-1:0]           miss_addr,
    input  logic                          vc_wb_valid,
    input  logic [`DC_XLEN-1:0]           vc_wb_addr,
    input  logic [`DC_BLOCK_BITS-1:0]     vc_wb_block,
    input  logic [`DC_MEM_TAG_BITS-1:0]   mem_response,
    input  logic [`DC_BLOCK_BITS-1:0]     mem_rdata,
    input  logic [`DC_MEM_TAG_BITS-1:0]   mem_tag,
    output logic                          fill_valid,
    output logic [`DC_XLEN-1:0]           fill_addr,
    output logic [`DC_BLOCK_BITS-1:0]     fill_block,
    output dcache_pkg::mem_cmd_t          mem_command,
    output logic [`DC_XLEN-1:0]           mem_addr,
    output logic [`DC_BLOCK_BITS-1:0]     mem_wdata
);

    // pending read, not yet accepted by memory
    logic                         rd_pending;
    // read accepted, waiting for its tag
    logic                         rd_wait;
    logic [`DC_XLEN-1:0]          rd_addr;
    logic [`DC_MEM_TAG_BITS-1:0]  rd_tag;

    // single write-back buffer entry
    logic                         wb_valid;
    logic [`DC_XLEN-1:0]          wb_addr;
    logic [`DC_BLOCK_BITS-1:0]    wb_data;

    logic accepted;
    logic issue_store;
    logic issue_load;

    assign accepted    = (mem_response != '0);
    assign issue_store = wb_valid && accepted;
    assign issue_load  = !wb_valid && rd_pending && accepted;

    // buffer goes out before the read
    always_comb begin
        mem_command = dcache_pkg::cmd_none;
        mem_addr    = '0;
        mem_wdata   = '0;
        if (wb_valid) begin
            mem_command = dcache_pkg::cmd_store;
            mem_addr    = wb_addr;
            mem_wdata   = wb_data;
        end else if (rd_pending) begin
            mem_command = dcache_pkg::cmd_load;
            mem_addr    = rd_addr;
        end
    end

    assign fill_valid = rd_wait && (mem_tag == rd_tag);
    assign fill_addr  = rd_addr;
    assign fill_block = mem_rdata;

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_pending <= 1'b0;
            rd_wait    <= 1'b0;
            wb_valid   <= 1'b0;
        end else begin
            if (miss_start) begin
                rd_pending <= 1'b1;
            end else if (issue_load) begin
                rd_pending <= 1'b0;
                rd_wait    <= 1'b1;
            end
            if (fill_valid) rd_wait <= 1'b0;
            if (issue_store) wb_valid <= 1'b0;
            if (vc_wb_valid) wb_valid <= 1'b1;   // buffer is always empty at a fill
        end
    end

    always_ff @(posedge clock) begin
        if (miss_start) rd_addr <= {miss_addr[`DC_XLEN-1:`DC_OFFSET_BITS],
                                    {`DC_OFFSET_BITS{1'b0}}};
        if (issue_load) rd_tag <= mem_response;
        if (vc_wb_valid) begin
            wb_addr <= vc_wb_addr;
            wb_data <= vc_wb_block;
        end
    end

endmodule

/* hw/dcache.sv */
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          req_valid,
    input  logic                          req_write,
    input  dcache_pkg::mem_size_t         req_size,
    input  logic [`DC_XLEN-1:0]           req_addr,
    input  logic [`DC_XLEN-1:0]           req_wdata,
    output logic                          stall,
    output logic                          resp_valid,
    output logic [31:0]                   resp_data,
    output dcache_pkg::mem_cmd_t          mem_command,
    output logic [`DC_XLEN-1:0]           mem_addr,
    output logic [`DC_BLOCK_BITS-1:0]     mem_wdata,
    input  logic [`DC_MEM_TAG_BITS-1:0]   mem_response,
    input  logic [`DC_BLOCK_BITS-1:0]     mem_rdata,
    input  logic [`DC_MEM_TAG_BITS-1:0]   mem_tag
);

    logic                       miss_start;
    logic [`DC_XLEN-1:0]        miss_addr;
    logic                       hold_write;
    dcache_pkg::mem_size_t      hold_size;
    logic [`DC_XLEN-1:0]        hold_addr;
    logic [`DC_XLEN-1:0]        hold_wdata;
    logic                       fill_valid;
    logic [`DC_XLEN-1:0]        fill_addr;
    logic [`DC_BLOCK_BITS-1:0]  fill_block;
    logic                       main_hit;
    logic [`DC_BLOCK_BITS-1:0]  main_hit_block;
    logic                       evict_valid;
    dcache_pkg::main_line_t     evict_line;
    logic [`DC_XLEN-1:0]        evict_addr;
    logic                       vc_hit;
    logic [`DC_BLOCK_BITS-1:0]  vc_hit_block;
    logic                       vc_wb_valid;
    logic [`DC_XLEN-1:0]        vc_wb_addr;
    logic [`DC_BLOCK_BITS-1:0]  vc_wb_block;

    dcache_ctrl u_ctrl (.*);

    main_cache_array u_main (.*);

    victim_cache u_victim (.*);

    miss_unit u_miss (.*);

endmodule

/* dv/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;   // 40 ns period
    end

    // reset covers the first two rising edges
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

/* dv/dcache_asserts.sv */
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_asserts (
    input logic                          clock,
    input logic                          reset,
    input logic                          stall,
    input logic                          resp_valid,
    input dcache_pkg::mem_cmd_t          mem_command,
    input logic [`DC_XLEN-1:0]           mem_addr,
    input logic [`DC_MEM_TAG_BITS-1:0]   mem_response
);

    int assert_errors = 0;   // failed assertions so far

    // back to back responses only while the pipeline is free to go
    resp_no_repeat: assert property (@(posedge clock) disable iff (reset)
        resp_valid |=> (!resp_valid || !stall))
        else begin
            $error("resp_valid high in two cycles in a row while stalled");
            assert_errors++;
        end

    // command and address wait for mem_response
    cmd_held: assert property (@(posedge clock) disable iff (reset)
        (mem_command != dcache_pkg::cmd_none && mem_response == '0)
            |=> ($stable(mem_command) && $stable(mem_addr)))
        else begin
            $error("memory command or address changed before acceptance");
            assert_errors++;
        end

    stall_after_reset: assert property (@(posedge clock) reset |=> !stall)
        else begin
            $error("stall high in the cycle after reset");
            assert_errors++;
        end

endmodule

bind dcache dcache_asserts u_asserts (
    .clock(clock),
    .reset(reset),
    .stall(stall),
    .resp_valid(resp_valid),
    .mem_command(mem_command),
    .mem_addr(mem_addr),
    .mem_response(mem_response)
);

/* dv/dcache_tb.sv */
`timescale 1ns/10ps
`include "dcache_cfg.svh"

module dcache_tb;

    localparam int op_load = 0;
    localparam int op_store = 1;
    localparam int op_slow_load = 2;   // load while memory holds mem_response low
    localparam int op_check_wb = 3;    // expect a write-back of the line at addr

    typedef struct {
        int          op;
        int          size;
        logic [31:0] addr;
        logic [31:0] wdata;
        bit          expect_hit;
    } step_t;

    logic clock;
    logic reset;
    logic req_valid = 1'b0;
    logic req_write = 1'b0;
    dcache_pkg::mem_size_t req_size = dcache_pkg::size_word;
    logic [`DC_XLEN-1:0] req_addr = '0;
    logic [`DC_XLEN-1:0] req_wdata = '0;
    logic stall;
    logic resp_valid;
    logic [31:0] resp_data;
    dcache_pkg::mem_cmd_t mem_command;
    logic [`DC_XLEN-1:0] mem_addr;
    logic [`DC_BLOCK_BITS-1:0] mem_wdata;
    logic [`DC_MEM_TAG_BITS-1:0] mem_response = '0;
    logic [`DC_BLOCK_BITS-1:0] mem_rdata = '0;
    logic [`DC_MEM_TAG_BITS-1:0] mem_tag = '0;

    logic [31:0] mem_words [logic [31:0]];   // memory model, changed by write-backs only
    logic [7:0]  ref_bytes [logic [31:0]];   // what the program should see
    logic [31:0] wb_addr_q [$];
    logic [63:0] wb_data_q [$];
    step_t steps [$];

    integer seed = 92847;
    int error_count = 0;
    int timeout_count = 0;
    int extra_delay = 0;
    int acc_delay = -1;
    int ret_count = 0;
    bit aborted = 1'b0;
    logic [3:0] next_tag = 4'd1;
    logic [3:0] ret_tag;
    logic [31:0] ret_addr;
    dcache_pkg::mem_cmd_t seen_cmd;
    logic [31:0] seen_addr;

    tb_clock_gen clock_gen (.clock(clock), .reset(reset));

    dcache DUT (.*);

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (mem_words.exists(addr)) return mem_words[addr];
        return addr ^ 32'h5a5a0000;   // untouched memory
    endfunction

    function automatic logic [7:0] ref_byte(input logic [31:0] addr);
        logic [31:0] w;
        if (ref_bytes.exists(addr)) return ref_bytes[addr];
        w = {addr[31:2], 2'b00} ^ 32'h5a5a0000;
        return w[{addr[1:0], 3'b000} +: 8];
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] addr, input int size);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < (1 << size); k++) begin
            v[8*k +: 8] = ref_byte(addr + k);
        end
        return v;
    endfunction

    function automatic logic [63:0] ref_line(input logic [31:0] addr);
        logic [63:0] v;
        for (int k = 0; k < 8; k++) begin
            v[8*k +: 8] = ref_byte(addr + k);
        end
        return v;
    endfunction

    // memory model with random acceptance delay and load data three cycles later
    always @(posedge clock) begin
        if (reset) begin
            mem_response <= '0;
            mem_tag <= '0;
            acc_delay = -1;
            ret_count = 0;
        end else begin
            mem_tag <= '0;
            if (ret_count > 0) begin
                ret_count = ret_count - 1;
                if (ret_count == 0) begin
                    mem_tag <= ret_tag;
                    mem_rdata <= {word_at(ret_addr + 4), word_at(ret_addr)};
                end
            end
            if (mem_response != '0) begin   // accepted at this edge
                if (mem_command == dcache_pkg::cmd_store) begin
                    mem_words[mem_addr] = mem_wdata[31:0];
                    mem_words[mem_addr + 4] = mem_wdata[63:32];
                    wb_addr_q.push_back(mem_addr);
                    wb_data_q.push_back(mem_wdata);
                end else if (mem_command == dcache_pkg::cmd_load) begin
                    ret_count = 3;
                    ret_tag = mem_response;
                    ret_addr = mem_addr;
                end
                mem_response <= '0;
                acc_delay = -1;
            end else if (mem_command != dcache_pkg::cmd_none) begin
                if (acc_delay < 0) begin
                    acc_delay = $unsigned($random(seed)) % 4 + extra_delay;
                    extra_delay = 0;
                    seen_cmd = mem_command;
                    seen_addr = mem_addr;
                end else if (mem_command != seen_cmd) begin
                    $display("ERR mem_command: got %h, expected %h", mem_command, seen_cmd);
                    error_count++;
                end else if (mem_addr != seen_addr) begin
                    $display("ERR mem_addr: got %h, expected %h", mem_addr, seen_addr);
                    error_count++;
                end
                if (acc_delay == 0) begin
                    mem_response <= next_tag;
                    next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
                end else begin
                    acc_delay = acc_delay - 1;
                end
            end
        end
    end

    task automatic add_step(input int op, input int size, input logic [31:0] addr,
                            input logic [31:0] wdata, input bit expect_hit);
        step_t s;
        s.op = op;
        s.size = size;
        s.addr = addr;
        s.wdata = wdata;
        s.expect_hit = expect_hit;
        steps.push_back(s);
    endtask

    task automatic build_table();
        add_step(op_load, 2, 32'h0100, 0, 0);             // cold miss
        add_step(op_load, 2, 32'h0104, 0, 1);
        add_step(op_load, 0, 32'h0103, 0, 1);
        add_step(op_store, 0, 32'h0101, 32'h000000ab, 1);
        add_step(op_store, 1, 32'h0106, 32'h0000beef, 1);
        add_step(op_load, 2, 32'h0100, 0, 1);
        add_step(op_load, 2, 32'h0104, 0, 1);
        add_step(op_load, 1, 32'h0102, 0, 1);
        add_step(op_load, 0, 32'h0107, 0, 1);
        add_step(op_store, 2, 32'h0208, 32'h12345678, 0); // store miss fills first
        add_step(op_load, 2, 32'h0208, 0, 1);
        add_step(op_load, 2, 32'h020c, 0, 1);
        add_step(op_store, 0, 32'h020e, 32'h0000005c, 1);
        add_step(op_load, 1, 32'h020e, 0, 1);
        add_step(op_load, 2, 32'h0180, 0, 0);             // same index as 0x100
        add_step(op_load, 2, 32'h0100, 0, 1);             // victim hit
        add_step(op_slow_load, 2, 32'h0328, 0, 0);
        add_step(op_store, 2, 32'h1010, 32'hd0000001, 0);
        add_step(op_store, 2, 32'h1090, 32'hd0000002, 0);
        add_step(op_store, 2, 32'h1110, 32'hd0000003, 0);
        add_step(op_store, 2, 32'h1190, 32'hd0000004, 0);
        add_step(op_store, 2, 32'h1210, 32'hd0000005, 0); // victim cache overflows
        add_step(op_check_wb, 0, 32'h1010, 0, 0);
        add_step(op_load, 2, 32'h1010, 0, 0);
        add_step(op_load, 2, 32'h1090, 0, 1);
        add_step(op_load, 2, 32'h1190, 0, 0);
    endtask

    task automatic apply_step(input step_t s);
        int waited;
        bit stall_ok;
        logic [31:0] expected;
        waited = 0;
        stall_ok = 1'b1;
        expected = expected_load(s.addr, s.size);
        if (s.op == op_store) begin
            for (int k = 0; k < (1 << s.size); k++) begin
                ref_bytes[s.addr + k] = s.wdata[8*k +: 8];
            end
        end
        if (s.op == op_slow_load) begin
            extra_delay = 8;
        end
        @(posedge clock);
        req_valid <= 1'b1;
        req_write <= (s.op == op_store);
        req_size  <= dcache_pkg::mem_size_t'(s.size);
        req_addr  <= s.addr;
        req_wdata <= s.wdata;
        @(negedge clock);
        while (stall && waited < 50) begin
            @(negedge clock);
            waited++;
        end
        if (stall) begin
            $display("timeout: cache stayed stalled before the request to %h", s.addr);
            timeout_count++;
            aborted = 1'b1;
        end else begin
            @(posedge clock);   // accepted at this edge
            req_valid <= 1'b0;
            @(negedge clock);
            waited = 1;
            while (!resp_valid && waited < 100) begin
                if (!stall && stall_ok) begin
                    $display("ERR stall at %h: got %h, expected %h", s.addr, stall, 1'b1);
                    error_count++;
                    stall_ok = 1'b0;
                end
                @(negedge clock);
                waited++;
            end
            if (!resp_valid) begin
                $display("timeout: no response for the request to %h", s.addr);
                timeout_count++;
                aborted = 1'b1;
            end else begin
                if (stall) begin
                    $display("ERR stall at %h: got %h, expected %h", s.addr, stall, 1'b0);
                    error_count++;
                end
                if (s.expect_hit && waited != 1) begin
                    $display("request to %h should hit but took %0d cycles", s.addr, waited);
                    error_count++;
                end
                if (!s.expect_hit && waited == 1) begin
                    $display("request to %h should miss but answered at once", s.addr);
                    error_count++;
                end
                if (s.op != op_store && resp_data !== expected) begin
                    $display("ERR resp_data at %h: got %h, expected %h",
                             s.addr, resp_data, expected);
                    error_count++;
                end
                if (s.expect_hit) begin
                    @(negedge clock);   // a read started by this request is visible now
                    if (mem_command == dcache_pkg::cmd_load) begin
                        $display("hit to %h sent a load to memory", s.addr);
                        error_count++;
                    end
                end
            end
        end
    endtask

    task automatic check_write_back(input logic [31:0] addr);
        int waited;
        logic [31:0] got_addr;
        logic [63:0] got_data;
        waited = 0;
        while (wb_addr_q.size() == 0 && waited < 50) begin
            @(negedge clock);
            waited++;
        end
        if (wb_addr_q.size() == 0) begin
            $display("timeout: no write-back reached memory for line %h", addr);
            timeout_count++;
            aborted = 1'b1;
        end else begin
            got_addr = wb_addr_q.pop_front();
            got_data = wb_data_q.pop_front();
            if (got_addr !== addr) begin
                $display("ERR mem_addr: got %h, expected %h", got_addr, addr);
                error_count++;
            end
            if (got_data !== ref_line(addr)) begin
                $display("ERR mem_wdata: got %h, expected %h", got_data, ref_line(addr));
                error_count++;
            end
        end
    endtask

    initial begin
        int waited;
        int assert_fails;
        waited = 0;
        build_table();
        @(negedge clock);
        while (reset && waited < 10) begin
            @(negedge clock);
            waited++;
        end
        if (reset) begin
            $display("timeout: reset never went low");
            timeout_count++;
            aborted = 1'b1;
        end else begin
            if (stall !== 1'b0) begin
                $display("ERR stall: got %h, expected %h", stall, 1'b0);
                error_count++;
            end
            if (resp_valid !== 1'b0) begin
                $display("ERR resp_valid: got %h, expected %h", resp_valid, 1'b0);
                error_count++;
            end
            if (mem_command !== dcache_pkg::cmd_none) begin
                $display("ERR mem_command: got %h, expected %h", mem_command,
                         dcache_pkg::cmd_none);
                error_count++;
            end
        end
        for (int i = 0; i < steps.size() && !aborted; i++) begin
            if (steps[i].op == op_check_wb) begin
                check_write_back(steps[i].addr);
            end else begin
                apply_step(steps[i]);
            end
        end
        assert_fails = DUT.u_asserts.assert_errors;
        $display("errors: %0d wrong values, %0d timeouts, %0d assertion failures",
                 error_count, timeout_count, assert_fails);
        if (error_count + timeout_count + assert_fails == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+include
hw/dcache_pkg.sv
hw/dcache_ctrl.sv
hw/main_cache_array.sv
hw/victim_cache.sv
hw/miss_unit.sv
hw/dcache.sv
dv/tb_clock_gen.sv
dv/dcache_asserts.sv
dv/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/dcache_pkg.sv
      - hw/dcache_ctrl.sv
      - hw/main_cache_array.sv
      - hw/victim_cache.sv
      - hw/miss_unit.sv
      - hw/dcache.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/tb_clock_gen.sv
      - dv/dcache_asserts.sv
      - dv/dcache_tb.sv
